// ==== sources.f ====
logic/xosera_pkg.sv
logic/bus_regs.sv
logic/xr_regs.sv
logic/video_timing.sv
logic/color_lut.sv
logic/intr_ctrl.sv
logic/xosera_main.sv
bench/xosera_assert.sv
bench/xosera_tb.sv

// ==== Makefile ====
# Verilator simulation of the xosera video core
VERILATOR ?= verilator
TOP       ?= xosera_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail on the fail message"
	@echo "  clean  remove build output and log"
	@echo "  help   list targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/xosera_tb.sv ====
// testbench for the xosera video core
// drives the CPU register bus, models palette, scroll and interrupt status,
// and checks pixels, register reads and interrupt pulses

module xosera_tb;

localparam int FRAME_CLKS   = xosera_pkg::H_TOTAL * xosera_pkg::V_TOTAL;
localparam int WATCH_FRAMES = 20;       // about 6 frames of tests plus margin

logic                   clk = 1'b0;
logic                   reset_i;
logic                   bus_cs_n;
logic                   bus_rd_nwr;
xosera_pkg::reg_num_t   bus_reg_num;
logic                   bus_bytesel;
logic [7:0]             bus_data_in;
logic [7:0]             bus_data_out;
logic                   bus_intr;
logic [3:0]             red, green, blue;
logic                   hsync, vsync, dv_de;
logic [1:0]             boot_select;

xosera_pkg::rgb_t       model_pal [16];     // expected palette
xosera_pkg::color_t     model_scroll;
string                  cur_test;
int                     errors = 0;
int                     err_start;
int                     tests_ok = 0;
int                     tests_bad = 0;
int                     pix_x;
logic                   pix_armed = 1'b0;
logic                   pix_done = 1'b0;
logic                   de_prev = 1'b0;

xosera_main DUT(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_data_in), .bus_data_o(bus_data_out),
    .bus_intr_o(bus_intr), .red_o(red), .green_o(green), .blue_o(blue),
    .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de), .boot_select_o(boot_select)
);

always #50 clk = ~clk;

// colour-bar pixel rule, index wraps mod 16
function automatic xosera_pkg::rgb_t expected_rgb(input int x);
    return model_pal[4'((x + int'(model_scroll)) % 16)];
endfunction

// pending bits after triggers and CPU clears
function automatic xosera_pkg::intr_t expected_status(input xosera_pkg::intr_t pending,
        input xosera_pkg::intr_t trig, input xosera_pkg::intr_t clr);
    return (pending | trig) & ~clr;
endfunction

task automatic check_rgb(input string what, input xosera_pkg::rgb_t exp,
        input xosera_pkg::rgb_t act);
    if (exp !== act) begin
        errors++;
        $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
        errors++;
        $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
        errors++;
        $display("mismatch %s %s expected %b actual %b", cur_test, what, exp, act);
    end
endtask

task automatic bus_write(input xosera_pkg::reg_num_t r, input logic bs, input logic [7:0] d);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b0;
    bus_reg_num <= r;
    bus_bytesel <= bs;
    bus_data_in <= d;
    @(posedge clk);
    bus_cs_n    <= 1'b1;
endtask

task automatic bus_read(input xosera_pkg::reg_num_t r, input logic bs, output logic [7:0] d);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b1;
    bus_reg_num <= r;
    bus_bytesel <= bs;
    @(posedge clk);
    bus_cs_n    <= 1'b1;
    @(negedge clk);
    d = bus_data_out;                   // loaded on the sampling edge
endtask

task automatic xr_write(input logic [6:0] addr, input logic [15:0] data);
    bus_write(xosera_pkg::XR_ADDR, 1'b1, {1'b0, addr});
    bus_write(xosera_pkg::XR_DATA, 1'b0, data[15:8]);
    bus_write(xosera_pkg::XR_DATA, 1'b1, data[7:0]);
endtask

// bus_intr_o samples at each falling edge
task automatic count_pulses(input int clocks, output int n);
    n = 0;
    repeat (clocks) begin
        @(negedge clk);
        if (bus_intr) n++;
    end
endtask

task automatic wait_vsync;
    do @(negedge clk); while (vsync !== 1'b1);
    do @(negedge clk); while (vsync !== 1'b0);      // start of vsync lines
endtask

task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
endtask

task automatic end_test;
    if (errors == err_start) begin
        tests_ok++;
        $display("test %s: ok", cur_test);
    end else begin
        tests_bad++;
        $display("test %s: failed with %0d errors", cur_test, errors - err_start);
    end
endtask

// pixel compare, one visible line from the rise of display enable
always @(negedge clk) begin
    if (pix_armed) begin
        if (!dv_de && pix_x != 0) begin
            pix_armed = 1'b0;
            pix_done  = 1'b1;
        end else if (dv_de && (!de_prev || pix_x != 0)) begin
            check_rgb($sformatf("pixel %0d", pix_x), expected_rgb(pix_x),
                xosera_pkg::rgb_t'({red, green, blue}));
            pix_x++;
        end
    end
    de_prev = dv_de;
end

initial begin
    #(WATCH_FRAMES * FRAME_CLKS * 100);
    $display("timeout: tests did not finish within %0d frames", WATCH_FRAMES);
    $display("FAIL: see errors above");
    $finish;
end

initial begin
    logic [7:0]         d;
    logic [7:0]         v;
    int                 n;
    xosera_pkg::intr_t  s;
    void'($urandom(32'h6048_bdab));
    reset_i     = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = xosera_pkg::SYS_STATUS;
    bus_bytesel = 1'b0;
    bus_data_in = 8'h00;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;

    start_test("reset");
    @(negedge clk);
    check_bit("bus_intr_o", 1'b0, bus_intr);
    check_bit("dv_de_o", 1'b0, dv_de);
    check_bit("hsync_o", 1'b1, hsync);          // syncs idle high
    check_bit("vsync_o", 1'b1, vsync);
    check_rgb("rgb", '0, xosera_pkg::rgb_t'({red, green, blue}));
    check_byte("boot_select_o", 8'h00, {6'b0, boot_select});
    bus_read(xosera_pkg::INT_CTRL, 1'b1, d);    // before first raster trigger lands
    check_byte("status", 8'h00, d);
    end_test();

    start_test("palette");
    bus_write(xosera_pkg::XR_ADDR, 1'b1, 8'h40);
    for (int i = 0; i < 16; i++) begin
        model_pal[i] = xosera_pkg::rgb_t'(12'($urandom));
        bus_write(xosera_pkg::XR_DATA, 1'b0, {4'h0, model_pal[i][11:8]});
        bus_write(xosera_pkg::XR_DATA, 1'b1, model_pal[i][7:0]);
    end
    model_scroll = 4'($urandom);
    xr_write(7'h02, {12'h000, model_scroll});
    repeat (4) @(posedge clk);                  // let the writes settle
    pix_x    = 0;
    pix_done = 1'b0;
    pix_armed = 1'b1;
    wait (pix_done);
    if (pix_x != xosera_pkg::H_VISIBLE) begin
        errors++;
        $display("%s: saw %0d visible pixels instead of 16", cur_test, pix_x);
    end
    end_test();

    start_test("mask");
    v = 8'($urandom);
    bus_write(xosera_pkg::INT_CTRL, 1'b0, v);
    bus_read(xosera_pkg::INT_CTRL, 1'b0, d);
    check_byte("mask", {5'b0, v[2:0]}, d);
    check_byte("boot_select_o", {6'b0, v[1:0]}, {6'b0, boot_select});
    end_test();

    start_test("video_intr");
    bus_write(xosera_pkg::INT_CTRL, 1'b0, 8'h01);   // VIDEO_INTR only
    bus_write(xosera_pkg::INT_CTRL, 1'b1, 8'h07);
    fork
        count_pulses(12, n);
        xr_write(7'h00, 16'h0001);
    join
    check_byte("first pulses", 8'd1, 8'(n));
    bus_read(xosera_pkg::INT_CTRL, 1'b1, d);
    check_bit("status bit 0", 1'b1, d[0]);
    fork
        count_pulses(12, n);
        xr_write(7'h00, 16'h0001);
    join
    check_byte("pending pulses", 8'd0, 8'(n));
    bus_write(xosera_pkg::INT_CTRL, 1'b1, 8'h01);
    bus_read(xosera_pkg::INT_CTRL, 1'b1, d);
    s = expected_status(3'b001, 3'b000, 3'b001);
    check_bit("cleared bit 0", s[xosera_pkg::VIDEO_INTR], d[0]);
    end_test();

    start_test("raster_intr");
    bus_write(xosera_pkg::INT_CTRL, 1'b0, 8'h04);   // LINE_INTR only
    xr_write(7'h01, 16'h0003);
    wait_vsync();
    bus_write(xosera_pkg::INT_CTRL, 1'b1, 8'h07);
    count_pulses(FRAME_CLKS, n);
    check_byte("line pulses", 8'd1, 8'(n));
    bus_read(xosera_pkg::INT_CTRL, 1'b1, d);
    check_byte("status", {5'b0, expected_status(3'b000, 3'b110, 3'b000)}, d);
    bus_write(xosera_pkg::INT_CTRL, 1'b0, 8'h00);
    bus_write(xosera_pkg::INT_CTRL, 1'b1, 8'h07);
    count_pulses(FRAME_CLKS, n);
    check_byte("masked pulses", 8'd0, 8'(n));
    end_test();

    start_test("sys_status");
    wait_vsync();
    bus_read(xosera_pkg::SYS_STATUS, 1'b0, d);
    check_bit("v_blank", 1'b1, d[1]);
    end_test();

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

// ==== bench/xosera_assert.sv ====
// concurrent checks on the video core top level
// blank colour outside display, no interrupt right after reset,
// and a fixed line length between hsync falls

module xosera_assert(
    input logic         clk,
    input logic         reset_i,
    input logic         dv_de_o,
    input logic [3:0]   red_o,
    input logic [3:0]   green_o,
    input logic [3:0]   blue_o,
    input logic         bus_intr_o,
    input logic         hsync_o
);

logic       hs_q;           // hsync one clock back
logic       seen_fall;      // first fall seen since reset
int         since_fall;     // clocks since last hsync fall

always_ff @(posedge clk) begin
    if (reset_i) begin
        hs_q       <= 1'b1;
        seen_fall  <= 1'b0;
        since_fall <= 0;
    end else begin
        hs_q <= hsync_o;
        if (hs_q && !hsync_o) begin
            seen_fall  <= 1'b1;
            since_fall <= 0;
        end else begin
            since_fall <= since_fall + 1;
        end
    end
end

blank_colour: assert property (@(posedge clk) disable iff (reset_i)
    !dv_de_o |-> ({red_o, green_o, blue_o} == 12'h000))
    else $error("colour not black outside display enable");

no_intr_after_reset: assert property (@(posedge clk)
    $past(reset_i) |-> !bus_intr_o)
    else $error("bus interrupt in cycle after reset");

hsync_period: assert property (@(posedge clk) disable iff (reset_i)
    (hs_q && !hsync_o && seen_fall) |-> (since_fall == xosera_pkg::H_TOTAL - 1))
    else $error("hsync fall spacing is not one line");

endmodule

bind xosera_main xosera_assert xosera_assert_i(.*);

// ==== logic/xosera_main.sv ====
// xosera video core, top level
// CPU register bus, XR registers, timing, colour lookup and interrupts
// colour and sync outputs come out three clocks after the counters

`default_nettype none

module xosera_main(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // active low strobe
    input  wire logic                   bus_rd_nwr_i,   // 1 = read
    input  wire xosera_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even byte
    input  wire logic [7:0]             bus_data_i,
    output logic [7:0]                  bus_data_o,
    output logic                        bus_intr_o,
    output logic [3:0]                  red_o,
    output logic [3:0]                  green_o,
    output logic [3:0]                  blue_o,
    output logic                        hsync_o,        // active low
    output logic                        vsync_o,        // active low
    output logic                        dv_de_o,
    output logic [1:0]                  boot_select_o
);

logic                   xr_wr;          // bus_regs -> xr_regs
xosera_pkg::xr_addr_t   xr_addr;
xosera_pkg::word_t      xr_data;
xosera_pkg::color_t     scroll;
xosera_pkg::vres_t      line_cmp;
logic                   pal_wr;         // xr_regs -> color_lut
xosera_pkg::color_t     pal_idx;
xosera_pkg::rgb_t       pal_data;
logic                   hsync;          // timing, before lookup delay
logic                   vsync;
logic                   dv_de;
logic                   h_blank;
logic                   v_blank;
xosera_pkg::color_t     color_idx;
xosera_pkg::rgb_t       rgb;
xosera_pkg::intr_t      intr_trigger;
xosera_pkg::intr_t      intr_mask;
xosera_pkg::intr_t      intr_clear;
xosera_pkg::intr_t      intr_status;

assign boot_select_o = intr_mask[1:0];  // low mask bits double as boot config
assign red_o         = rgb.r;
assign green_o       = rgb.g;
assign blue_o        = rgb.b;

bus_regs bus_regs(
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .intr_status_i(intr_status),
    .h_blank_i(h_blank),
    .v_blank_i(v_blank),
    .bus_data_o(bus_data_o),
    .xr_wr_o(xr_wr),
    .xr_addr_o(xr_addr),
    .xr_data_o(xr_data),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear)
);

xr_regs xr_regs(
    .clk(clk),
    .reset_i(reset_i),
    .xr_wr_i(xr_wr),
    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .scroll_o(scroll),
    .line_cmp_o(line_cmp),
    .pal_wr_o(pal_wr),
    .pal_idx_o(pal_idx),
    .pal_data_o(pal_data),
    .video_intr_o(intr_trigger[xosera_pkg::VIDEO_INTR])
);

video_timing video_timing(
    .clk(clk),
    .reset_i(reset_i),
    .scroll_i(scroll),
    .line_cmp_i(line_cmp),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de),
    .h_blank_o(h_blank),
    .v_blank_o(v_blank),
    .color_idx_o(color_idx),
    .vblank_intr_o(intr_trigger[xosera_pkg::VBLANK_INTR]),
    .line_intr_o(intr_trigger[xosera_pkg::LINE_INTR])
);

color_lut color_lut(
    .clk(clk),
    .reset_i(reset_i),
    .pal_wr_i(pal_wr),
    .pal_idx_i(pal_idx),
    .pal_data_i(pal_data),
    .color_idx_i(color_idx),
    .hsync_i(hsync),
    .vsync_i(vsync),
    .dv_de_i(dv_de),
    .rgb_o(rgb),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o)
);

intr_ctrl intr_ctrl(
    .clk(clk),
    .reset_i(reset_i),
    .intr_trigger_i(intr_trigger),
    .intr_mask_i(intr_mask),
    .intr_clear_i(intr_clear),
    .intr_status_o(intr_status),
    .bus_intr_o(bus_intr_o)
);

endmodule

`default_nettype wire

// ==== logic/intr_ctrl.sv ====
// interrupt controller
// latches triggers into pending status, applies CPU clears and pulses
// the bus interrupt for each newly pending enabled trigger

`default_nettype none

module intr_ctrl(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xosera_pkg::intr_t      intr_trigger_i, // one cycle sources
    input  wire xosera_pkg::intr_t      intr_mask_i,    // enabled sources
    input  wire xosera_pkg::intr_t      intr_clear_i,   // CPU ack
    output xosera_pkg::intr_t           intr_status_o,  // pending
    output logic                        bus_intr_o
);

xosera_pkg::intr_t  new_intr;           // enabled and not yet pending

assign new_intr = intr_trigger_i & intr_mask_i & ~intr_status_o;

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        bus_intr_o    <= |new_intr;
        // every trigger is recorded, mask only gates the bus pulse
        intr_status_o <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
    end
end

endmodule

`default_nettype wire

// ==== logic/color_lut.sv ====
// colour lookup
// 16 entry palette with registered read, blanked output stage, and a
// two stage delay on syncs and display enable to match the colour path

`default_nettype none

module color_lut(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   pal_wr_i,
    input  wire xosera_pkg::color_t     pal_idx_i,
    input  wire xosera_pkg::rgb_t       pal_data_i,
    input  wire xosera_pkg::color_t     color_idx_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    input  wire logic                   dv_de_i,
    output xosera_pkg::rgb_t            rgb_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

xosera_pkg::rgb_t   pal_mem [16];       // palette, not reset
xosera_pkg::rgb_t   lut_rgb;            // lookup result, stage 1
logic               hsync_1;
logic               vsync_1;
logic               dv_de_1;

// palette write port and registered read
always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_idx_i] <= pal_data_i;
    end
    lut_rgb <= pal_mem[color_idx_i];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_1 <= 1'b1;
        vsync_1 <= 1'b1;
        dv_de_1 <= 1'b0;
        hsync_o <= 1'b1;
        vsync_o <= 1'b1;
        dv_de_o <= 1'b0;
        rgb_o   <= '0;
    end else begin
        hsync_1 <= hsync_i;             // stage 1, lookup in flight
        vsync_1 <= vsync_i;
        dv_de_1 <= dv_de_i;
        hsync_o <= hsync_1;             // stage 2, aligned with rgb_o
        vsync_o <= vsync_1;
        dv_de_o <= dv_de_1;
        rgb_o   <= dv_de_1 ? lut_rgb : '0;  // black outside display
    end
end

endmodule

`default_nettype wire

// ==== logic/video_timing.sv ====
// video timing generator
// h/v counters for the tiny mode, registered syncs, blanking and display
// enable, scrolled colour-bar index and the raster interrupt triggers
// all outputs are one clock behind the counters

`default_nettype none

module video_timing(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xosera_pkg::color_t     scroll_i,
    input  wire xosera_pkg::vres_t      line_cmp_i,
    output logic                        hsync_o,        // active low
    output logic                        vsync_o,        // active low
    output logic                        dv_de_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o,
    output xosera_pkg::color_t          color_idx_o,
    output logic                        vblank_intr_o,
    output logic                        line_intr_o
);

xosera_pkg::hres_t  h_count;
xosera_pkg::vres_t  v_count;
logic               h_last;             // last clock of line
logic               v_last;             // last line of frame
logic               h_vis;
logic               v_vis;
logic               h_sync_on;
logic               v_sync_on;

assign h_last    = (h_count == xosera_pkg::hres_t'(xosera_pkg::H_TOTAL - 1));
assign v_last    = (v_count == xosera_pkg::vres_t'(xosera_pkg::V_TOTAL - 1));
assign h_vis     = (h_count < xosera_pkg::hres_t'(xosera_pkg::H_VISIBLE));
assign v_vis     = (v_count < xosera_pkg::vres_t'(xosera_pkg::V_VISIBLE));
assign h_sync_on = (h_count >= xosera_pkg::hres_t'(xosera_pkg::H_VISIBLE + xosera_pkg::H_FRONT))
    && (h_count < xosera_pkg::hres_t'(xosera_pkg::H_VISIBLE + xosera_pkg::H_FRONT
    + xosera_pkg::H_SYNC));
assign v_sync_on = (v_count >= xosera_pkg::vres_t'(xosera_pkg::V_VISIBLE + xosera_pkg::V_FRONT))
    && (v_count < xosera_pkg::vres_t'(xosera_pkg::V_VISIBLE + xosera_pkg::V_FRONT
    + xosera_pkg::V_SYNC));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count       <= '0;
        v_count       <= '0;
        hsync_o       <= 1'b1;          // syncs idle high
        vsync_o       <= 1'b1;
        dv_de_o       <= 1'b0;
        h_blank_o     <= 1'b0;
        v_blank_o     <= 1'b0;
        vblank_intr_o <= 1'b0;
        line_intr_o   <= 1'b0;
    end else begin
        h_count <= h_last ? '0 : h_count + 5'd1;
        if (h_last) begin
            v_count <= v_last ? '0 : v_count + 4'd1;
        end
        hsync_o   <= ~h_sync_on;
        vsync_o   <= ~v_sync_on;
        dv_de_o   <= h_vis & v_vis;
        h_blank_o <= ~h_vis;
        v_blank_o <= ~v_vis;
        // raster triggers at start of line
        vblank_intr_o <= (h_count == '0)
            && (v_count == xosera_pkg::vres_t'(xosera_pkg::V_VISIBLE));
        line_intr_o   <= (h_count == '0) && (v_count == line_cmp_i);
    end
end

// colour bars, x plus scroll wraps mod 16
always_ff @(posedge clk) begin
    color_idx_o <= h_count[3:0] + scroll_i;
end

endmodule

`default_nettype wire

// ==== logic/xr_regs.sv ====
// XR register decode
// splits XR writes on address bit 6 into palette writes and the video
// registers, holds scroll and line compare, and fires the video interrupt

`default_nettype none

module xr_regs(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   xr_wr_i,        // one cycle write strobe
    input  wire xosera_pkg::xr_addr_t   xr_addr_i,
    input  wire xosera_pkg::word_t      xr_data_i,
    output xosera_pkg::color_t          scroll_o,       // playfield scroll
    output xosera_pkg::vres_t           line_cmp_o,     // raster compare line
    output logic                        pal_wr_o,
    output xosera_pkg::color_t          pal_idx_o,
    output xosera_pkg::rgb_t            pal_data_o,
    output logic                        video_intr_o    // one cycle trigger
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        scroll_o     <= '0;
        line_cmp_o   <= '0;
        pal_wr_o     <= 1'b0;
        video_intr_o <= 1'b0;
    end else begin
        pal_wr_o     <= 1'b0;
        video_intr_o <= 1'b0;
        if (xr_wr_i) begin
            if (xr_addr_i[6]) begin
                pal_wr_o <= 1'b1;       // palette region
            end else begin
                case (xosera_pkg::xr_reg_t'(xr_addr_i[5:0]))
                    xosera_pkg::XR_VID_INTR:  video_intr_o <= xr_data_i[0];
                    xosera_pkg::XR_LINE_CMP:  line_cmp_o   <= xr_data_i[3:0];
                    xosera_pkg::XR_PF_SCROLL: scroll_o     <= xr_data_i[3:0];
                    default: ;          // unmapped, dropped
                endcase
            end
        end
    end
end

// palette entry and colour ride along with pal_wr_o
always_ff @(posedge clk) begin
    if (xr_wr_i && xr_addr_i[6]) begin
        pal_idx_o  <= xr_addr_i[3:0];
        pal_data_o <= xr_data_i[11:0];  // r,g,b nibbles
    end
end

endmodule

`default_nettype wire

// ==== logic/bus_regs.sv ====
// CPU register interface
// turns single-cycle bus strobes into XR writes, interrupt mask and
// clear, and builds the 8-bit read data
// even byte (bytesel 0) is the high half of a 16-bit register

`default_nettype none

module bus_regs(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // strobe, active low
    input  wire logic                   bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire xosera_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even (high) byte
    input  wire logic [7:0]             bus_data_i,
    input  wire xosera_pkg::intr_t      intr_status_i,  // pending interrupts
    input  wire logic                   h_blank_i,
    input  wire logic                   v_blank_i,
    output logic [7:0]                  bus_data_o,
    output logic                        xr_wr_o,        // one cycle XR write
    output xosera_pkg::xr_addr_t        xr_addr_o,
    output xosera_pkg::word_t           xr_data_o,
    output xosera_pkg::intr_t           intr_mask_o,
    output xosera_pkg::intr_t           intr_clear_o    // one cycle clear pulse
);

xosera_pkg::xr_addr_t   xr_addr;        // current XR address, post-increments
logic [7:0]             data_hi;        // latched even byte of XR_DATA
logic [7:0]             rd_data;        // read mux
logic                   wr_cycle;
logic                   rd_cycle;

assign wr_cycle = ~bus_cs_n_i & ~bus_rd_nwr_i;
assign rd_cycle = ~bus_cs_n_i & bus_rd_nwr_i;

// read data for the register being addressed
always_comb begin
    rd_data = 8'h00;
    case (bus_reg_num_i)
        xosera_pkg::SYS_STATUS: begin
            if (!bus_bytesel_i) begin
                rd_data = {6'b0, v_blank_i, h_blank_i};
            end
        end
        xosera_pkg::INT_CTRL: begin
            rd_data = bus_bytesel_i ? {5'b0, intr_status_i} : {5'b0, intr_mask_o};
        end
        default: rd_data = 8'h00;       // nothing else reads back
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        xr_addr      <= '0;
        xr_wr_o      <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        bus_data_o   <= 8'h00;
    end else begin
        xr_wr_o      <= 1'b0;           // strobes default low
        intr_clear_o <= '0;
        if (rd_cycle) begin
            bus_data_o <= rd_data;      // held until next read
        end
        if (wr_cycle) begin
            case (bus_reg_num_i)
                xosera_pkg::INT_CTRL: begin
                    if (bus_bytesel_i) begin
                        intr_clear_o <= bus_data_i[2:0];    // ack pending bits
                    end else begin
                        intr_mask_o  <= bus_data_i[2:0];
                    end
                end
                xosera_pkg::XR_ADDR: begin
                    // even byte lies above the 7-bit XR space
                    if (bus_bytesel_i) begin
                        xr_addr <= bus_data_i[6:0];
                    end
                end
                xosera_pkg::XR_DATA: begin
                    if (bus_bytesel_i) begin
                        xr_wr_o <= 1'b1;
                        xr_addr <= xr_addr + 7'd1;          // auto-increment
                    end
                end
                default: ;                  // SYS_STATUS and unused regs
            endcase
        end
    end
end

// XR write payload, captured with the odd XR_DATA byte
always_ff @(posedge clk) begin
    if (wr_cycle && bus_reg_num_i == xosera_pkg::XR_DATA) begin
        if (!bus_bytesel_i) begin
            data_hi <= bus_data_i;
        end else begin
            xr_addr_o <= xr_addr;           // address before increment
            xr_data_o <= {data_hi, bus_data_i};
        end
    end
end

endmodule

`default_nettype wire

// ==== logic/xosera_pkg.sv ====
// xosera video core shared definitions
// tiny simulation video mode, bus register numbers, XR register map
// and the common data types used across the core

package xosera_pkg;

    // horizontal timing, in pixel clocks
    localparam int H_VISIBLE = 16;      // visible pixels per line
    localparam int H_FRONT   = 2;       // front porch, sync starts after this
    localparam int H_SYNC    = 3;       // hsync width
    localparam int H_TOTAL   = 24;      // clocks per line

    // vertical timing, in lines
    localparam int V_VISIBLE = 8;       // visible lines
    localparam int V_FRONT   = 1;       // front porch lines
    localparam int V_SYNC    = 2;       // vsync width
    localparam int V_TOTAL   = 12;      // lines per frame

    typedef logic [4:0]  hres_t;        // h counter, holds 0..H_TOTAL-1
    typedef logic [3:0]  vres_t;        // v counter, holds 0..V_TOTAL-1
    typedef logic [3:0]  color_t;       // palette index
    typedef logic [15:0] word_t;        // XR data word
    typedef logic [6:0]  xr_addr_t;     // bit 6 selects palette

    // 12-bit colour as packed nibbles
    typedef struct packed {
        logic [3:0] r;                  // red, msb nibble
        logic [3:0] g;
        logic [3:0] b;                  // blue, lsb nibble
    } rgb_t;

    // CPU visible registers, others ignored
    typedef enum logic [3:0] {
        SYS_STATUS = 4'h0,              // blanking status
        INT_CTRL   = 4'h1,              // even mask, odd status/clear
        XR_ADDR    = 4'h2,              // XR address
        XR_DATA    = 4'h3               // XR data, write on odd byte
    } reg_num_t;

    // video XR registers (address bit 6 clear)
    typedef enum logic [5:0] {
        XR_VID_INTR  = 6'h00,           // bit 0 fires video interrupt
        XR_LINE_CMP  = 6'h01,           // raster line compare
        XR_PF_SCROLL = 6'h02            // playfield colour-bar scroll
    } xr_reg_t;

    typedef logic [2:0] intr_t;         // interrupt bit vector

    localparam int VIDEO_INTR  = 0;     // XR_VID_INTR write
    localparam int VBLANK_INTR = 1;     // start of vertical blank
    localparam int LINE_INTR   = 2;     // line compare match

endpackage
